// ==== verilog/id_defines.svh ====
`ifndef ID_DEFINES_SVH
`define ID_DEFINES_SVH

// datapath and instruction word width
`define ID_DATA_W 32

// register file geometry
`define ID_NUM_REGS 32
`define ID_REG_AW 5

// primary opcode field
`define ID_OP_W 6

// rs and rt, one forwarding unit each
`define ID_NUM_SRC 2

`endif

// ==== verilog/id_pkg.sv ====
`include "id_defines.svh"

package id_pkg;

    // fields pulled out of one instruction word
    typedef struct packed {
        logic [`ID_OP_W-1:0]   opcode;
        logic [`ID_REG_AW-1:0] rs;
        logic [`ID_REG_AW-1:0] rt;
        logic [`ID_REG_AW-1:0] rd;
        logic [`ID_DATA_W-1:0] immediate;
        logic [25:0]           jump_target;
    } id_fields_t;

    // operand source picked by a forwarding unit
    typedef enum logic [1:0] {
        FWD_BANK   = 2'd0,
        FWD_MEM_WB = 2'd2,
        FWD_EX_MEM = 2'd1,
        FWD_ID_EX  = 2'd3
    } fwd_sel_e;

endpackage

// ==== verilog/fwd_src_if.sv ====
`timescale 1ns/1ps
`include "id_defines.svh"

interface fwd_src_if;

    // destination register of each later stage
    logic [`ID_REG_AW-1:0] rd_id_ex;
    logic [`ID_REG_AW-1:0] rd_ex_mem;
    logic [`ID_REG_AW-1:0] rd_mem_wb;

    // register write flags
    logic wr_id_ex;
    logic wr_ex_mem;
    logic wr_mem_wb;

    // result values available for forwarding
    logic [`ID_DATA_W-1:0] data_id_ex;
    logic [`ID_DATA_W-1:0] data_ex_mem;
    logic [`ID_DATA_W-1:0] data_mem_wb;

    modport src (
        output rd_id_ex, rd_ex_mem, rd_mem_wb,
        output wr_id_ex, wr_ex_mem, wr_mem_wb,
        output data_id_ex, data_ex_mem, data_mem_wb
    );

    modport dst (
        input rd_id_ex, rd_ex_mem, rd_mem_wb,
        input wr_id_ex, wr_ex_mem, wr_mem_wb,
        input data_id_ex, data_ex_mem, data_mem_wb
    );

endinterface

// ==== verilog/field_decoder.sv ====
`timescale 1ns/1ps
`include "id_defines.svh"

module field_decoder
    import id_pkg::*;
(
    input  logic [`ID_DATA_W-1:0] i_instruction,
    output id_fields_t            o_fields
);

    // sign bit of the 16-bit immediate
    logic imm_sign;

    assign imm_sign = i_instruction[15];

    // ********************************************************************
    // fixed MIPS field positions
    // ********************************************************************
    assign o_fields.opcode = i_instruction[31:26];
    assign o_fields.rs     = i_instruction[25:21];
    assign o_fields.rt     = i_instruction[20:16];
    assign o_fields.rd     = i_instruction[15:11];

    // I-type immediate, sign extended to full width
    assign o_fields.immediate = {{(`ID_DATA_W-16){imm_sign}}, i_instruction[15:0]};

    // J-type target, left unshifted
    assign o_fields.jump_target = i_instruction[25:0];

endmodule

// ==== verilog/register_bank.sv ====
`timescale 1ns/1ps
`include "id_defines.svh"

module register_bank (
    input  logic                  clk,
    input  logic                  i_rst_n,
    input  logic                  i_write_enable,
    input  logic [`ID_REG_AW-1:0] i_w_dir,
    input  logic [`ID_DATA_W-1:0] i_w_data,
    input  logic [`ID_REG_AW-1:0] i_rd_addr_a,
    input  logic [`ID_REG_AW-1:0] i_rd_addr_b,
    output logic [`ID_DATA_W-1:0] o_rd_data_a,
    output logic [`ID_DATA_W-1:0] o_rd_data_b
);

    logic [`ID_DATA_W-1:0] regs [`ID_NUM_REGS];
    logic                  bypass_a;
    logic                  bypass_b;

    // ********************************************************************
    // write port
    // ********************************************************************
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < `ID_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_write_enable && (i_w_dir != '0)) begin
            regs[i_w_dir] <= i_w_data;
        end
    end

    // ********************************************************************
    // read ports
    // ********************************************************************
    // write-back hitting a read address this cycle goes straight through
    assign bypass_a = i_write_enable && (i_w_dir == i_rd_addr_a);
    assign bypass_b = i_write_enable && (i_w_dir == i_rd_addr_b);

    // $zero always reads back as zero
    assign o_rd_data_a = (i_rd_addr_a == '0) ? '0 :
                         bypass_a            ? i_w_data :
                                               regs[i_rd_addr_a];

    assign o_rd_data_b = (i_rd_addr_b == '0) ? '0 :
                         bypass_b            ? i_w_data :
                                               regs[i_rd_addr_b];

endmodule

// ==== verilog/operand_forward.sv ====
`timescale 1ns/1ps
`include "id_defines.svh"

module operand_forward
    import id_pkg::*;
(
    input  logic [`ID_REG_AW-1:0] i_src_addr,
    input  logic [`ID_DATA_W-1:0] i_bank_data,
    fwd_src_if.dst                fwd,
    output fwd_sel_e              o_sel,
    output logic [`ID_DATA_W-1:0] o_operand
);

    logic hit_id_ex;
    logic hit_ex_mem;
    logic hit_mem_wb;

    // a stage only counts if it really writes the register we read
    assign hit_id_ex  = fwd.wr_id_ex  && (fwd.rd_id_ex  == i_src_addr);
    assign hit_ex_mem = fwd.wr_ex_mem && (fwd.rd_ex_mem == i_src_addr);
    assign hit_mem_wb = fwd.wr_mem_wb && (fwd.rd_mem_wb == i_src_addr);

    // youngest producer wins, $zero is never forwarded
    always_comb begin
        o_sel     = FWD_BANK;
        o_operand = i_bank_data;
        if (i_src_addr != '0) begin
            if (hit_id_ex) begin
                o_sel     = FWD_ID_EX;
                o_operand = fwd.data_id_ex;
            end else if (hit_ex_mem) begin
                o_sel     = FWD_EX_MEM;
                o_operand = fwd.data_ex_mem;
            end else if (hit_mem_wb) begin
                o_sel     = FWD_MEM_WB;
                o_operand = fwd.data_mem_wb;
            end
        end
    end

endmodule

// ==== verilog/id_ex_latch.sv ====
`timescale 1ns/1ps
`include "id_defines.svh"

module id_ex_latch
    import id_pkg::*;
(
    input  logic                  clk,
    input  logic                  i_rst_n,
    input  logic                  i_stall,
    input  logic                  i_jump_brch,
    input  logic [`ID_DATA_W-1:0] i_pc,
    input  id_fields_t            i_fields,
    input  logic [`ID_DATA_W-1:0] i_operand_a,
    input  logic [`ID_DATA_W-1:0] i_operand_b,
    input  logic [`ID_DATA_W-1:0] i_bank_a,
    input  logic [`ID_DATA_W-1:0] i_bank_b,
    output logic                  o_valid,
    output logic [`ID_OP_W-1:0]   o_op,
    output logic [`ID_DATA_W-1:0] o_reg_a,
    output logic [`ID_DATA_W-1:0] o_reg_b,
    output logic [`ID_DATA_W-1:0] o_reg_a_branch,
    output logic [`ID_DATA_W-1:0] o_reg_b_branch,
    output logic [`ID_DATA_W-1:0] o_immediate,
    output logic [25:0]           o_jmp_direc,
    output logic [`ID_REG_AW-1:0] o_dir_rs,
    output logic [`ID_REG_AW-1:0] o_dir_rt,
    output logic [`ID_REG_AW-1:0] o_dir_rd
);

    logic [`ID_DATA_W-1:0] next_reg_a;

    // jumps and branches hand the PC to the ALU as operand A
    assign next_reg_a = i_jump_brch ? i_pc : i_operand_a;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_valid        <= 1'b0;
            o_op           <= '0;
            o_reg_a        <= '0;
            o_reg_b        <= '0;
            o_reg_a_branch <= '0;
            o_reg_b_branch <= '0;
            o_immediate    <= '0;
            o_jmp_direc    <= '0;
            o_dir_rs       <= '0;
            o_dir_rt       <= '0;
            o_dir_rd       <= '0;
        end else if (!i_stall) begin
            o_valid        <= 1'b1;
            o_op           <= i_fields.opcode;
            o_reg_a        <= next_reg_a;
            o_reg_b        <= i_operand_b;
            // branch compare uses the raw bank values
            o_reg_a_branch <= i_bank_a;
            o_reg_b_branch <= i_bank_b;
            o_immediate    <= i_fields.immediate;
            o_jmp_direc    <= i_fields.jump_target;
            o_dir_rs       <= i_fields.rs;
            o_dir_rt       <= i_fields.rt;
            o_dir_rd       <= i_fields.rd;
        end
    end

endmodule

// ==== verilog/id_stage.sv ====
`timescale 1ns/1ps
`include "id_defines.svh"

module id_stage
    import id_pkg::*;
(
    input  logic                  clk,
    input  logic                  i_rst_n,
    input  logic                  i_stall,
    input  logic [`ID_DATA_W-1:0] i_instruction,
    input  logic [`ID_DATA_W-1:0] i_pc,
    input  logic                  i_jump_brch,
    input  logic [`ID_REG_AW-1:0] i_w_dir,
    input  logic [`ID_DATA_W-1:0] i_w_data,
    input  logic                  i_write_enable,
    input  logic [`ID_REG_AW-1:0] i_rd_id_ex,
    input  logic [`ID_REG_AW-1:0] i_rd_ex_mem,
    input  logic [`ID_REG_AW-1:0] i_rd_mem_wb,
    input  logic                  i_reg_wr_id_ex,
    input  logic                  i_reg_wr_ex_mem,
    input  logic                  i_reg_wr_mem_wb,
    input  logic [`ID_DATA_W-1:0] i_data_id_ex,
    input  logic [`ID_DATA_W-1:0] i_data_ex_mem,
    input  logic [`ID_DATA_W-1:0] i_data_mem_wb,
    output logic                  o_valid,
    output logic [`ID_OP_W-1:0]   o_op,
    output logic [`ID_DATA_W-1:0] o_reg_a,
    output logic [`ID_DATA_W-1:0] o_reg_b,
    output logic [`ID_DATA_W-1:0] o_reg_a_branch,
    output logic [`ID_DATA_W-1:0] o_reg_b_branch,
    output logic [`ID_DATA_W-1:0] o_immediate,
    output logic [25:0]           o_jmp_direc,
    output logic [`ID_REG_AW-1:0] o_dir_rs,
    output logic [`ID_REG_AW-1:0] o_dir_rt,
    output logic [`ID_REG_AW-1:0] o_dir_rd
);

    id_fields_t            fields;
    logic [`ID_REG_AW-1:0] src_addr    [`ID_NUM_SRC];
    logic [`ID_DATA_W-1:0] bank_data   [`ID_NUM_SRC];
    logic [`ID_DATA_W-1:0] fwd_operand [`ID_NUM_SRC];
    fwd_sel_e              fwd_sel     [`ID_NUM_SRC];

    fwd_src_if u_fwd_src ();

    // later-stage results arrive as plain ports
    assign u_fwd_src.rd_id_ex    = i_rd_id_ex;
    assign u_fwd_src.rd_ex_mem   = i_rd_ex_mem;
    assign u_fwd_src.rd_mem_wb   = i_rd_mem_wb;
    assign u_fwd_src.wr_id_ex    = i_reg_wr_id_ex;
    assign u_fwd_src.wr_ex_mem   = i_reg_wr_ex_mem;
    assign u_fwd_src.wr_mem_wb   = i_reg_wr_mem_wb;
    assign u_fwd_src.data_id_ex  = i_data_id_ex;
    assign u_fwd_src.data_ex_mem = i_data_ex_mem;
    assign u_fwd_src.data_mem_wb = i_data_mem_wb;

    field_decoder u_field_decoder (
        .i_instruction (i_instruction),
        .o_fields      (fields)
    );

    // index 0 is rs, index 1 is rt
    assign src_addr[0] = fields.rs;
    assign src_addr[1] = fields.rt;

    register_bank u_register_bank (
        .clk            (clk),
        .i_rst_n        (i_rst_n),
        .i_write_enable (i_write_enable),
        .i_w_dir        (i_w_dir),
        .i_w_data       (i_w_data),
        .i_rd_addr_a    (src_addr[0]),
        .i_rd_addr_b    (src_addr[1]),
        .o_rd_data_a    (bank_data[0]),
        .o_rd_data_b    (bank_data[1])
    );

    // ********************************************************************
    // one forwarding unit per source operand
    // ********************************************************************
    for (genvar g = 0; g < `ID_NUM_SRC; g++) begin : g_fwd
        operand_forward u_operand_forward (
            .i_src_addr  (src_addr[g]),
            .i_bank_data (bank_data[g]),
            .fwd         (u_fwd_src.dst),
            .o_sel       (fwd_sel[g]),
            .o_operand   (fwd_operand[g])
        );
    end

    id_ex_latch u_id_ex_latch (
        .clk            (clk),
        .i_rst_n        (i_rst_n),
        .i_stall        (i_stall),
        .i_jump_brch    (i_jump_brch),
        .i_pc           (i_pc),
        .i_fields       (fields),
        .i_operand_a    (fwd_operand[0]),
        .i_operand_b    (fwd_operand[1]),
        .i_bank_a       (bank_data[0]),
        .i_bank_b       (bank_data[1]),
        .o_valid        (o_valid),
        .o_op           (o_op),
        .o_reg_a        (o_reg_a),
        .o_reg_b        (o_reg_b),
        .o_reg_a_branch (o_reg_a_branch),
        .o_reg_b_branch (o_reg_b_branch),
        .o_immediate    (o_immediate),
        .o_jmp_direc    (o_jmp_direc),
        .o_dir_rs       (o_dir_rs),
        .o_dir_rt       (o_dir_rt),
        .o_dir_rd       (o_dir_rd)
    );

endmodule

// ==== tb/id_stage_sva.sv ====
`timescale 1ns/1ps
`include "id_defines.svh"

module id_stage_sva
    import id_pkg::*;
(
    input logic     clk,
    input logic     i_rst_n,
    input logic     i_stall,
    input logic     i_valid,
    input logic [`ID_OP_W + 5*`ID_DATA_W + 26 + 3*`ID_REG_AW:0] i_latched,
    input logic [`ID_REG_AW-1:0] i_addr_rs,
    input logic [`ID_REG_AW-1:0] i_addr_rt,
    input fwd_sel_e i_sel_rs,
    input fwd_sel_e i_sel_rt
);

    a_valid_in_reset: assert property (@(posedge clk) !i_rst_n |-> !i_valid)
        else $error("o_valid high while reset is active");

    // a stalled edge must not move any latched output
    a_stall_hold: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_stall |=> $stable(i_latched))
        else $error("latch outputs changed on a stalled edge");

    a_zero_rs: assert property (@(posedge clk) (i_addr_rs == '0) |-> (i_sel_rs == FWD_BANK))
        else $error("rs forwarding selected a stage for register 0");

    a_zero_rt: assert property (@(posedge clk) (i_addr_rt == '0) |-> (i_sel_rt == FWD_BANK))
        else $error("rt forwarding selected a stage for register 0");

endmodule

bind id_stage id_stage_sva u_id_stage_sva (
    .clk       (clk),
    .i_rst_n   (i_rst_n),
    .i_stall   (i_stall),
    .i_valid   (o_valid),
    .i_latched ({o_valid, o_op, o_reg_a, o_reg_b, o_reg_a_branch, o_reg_b_branch,
                 o_immediate, o_jmp_direc, o_dir_rs, o_dir_rt, o_dir_rd}),
    .i_addr_rs (src_addr[0]),
    .i_addr_rt (src_addr[1]),
    .i_sel_rs  (fwd_sel[0]),
    .i_sel_rt  (fwd_sel[1])
);

// ==== tb/id_stage_tb.sv ====
`timescale 1ns/1ps
`include "id_defines.svh"

module id_stage_tb;

    localparam int NUM_ROWS = 13;
    localparam int NUM_PRE  = 9;

    // operand source expected for a row
    localparam logic [2:0] S_BANK   = 3'd0;
    localparam logic [2:0] S_ID_EX  = 3'd1;
    localparam logic [2:0] S_EX_MEM = 3'd2;
    localparam logic [2:0] S_MEM_WB = 3'd3;
    localparam logic [2:0] S_PC     = 3'd4;

    localparam logic [31:0] D_ID_EX  = 32'h1111_a0a0;
    localparam logic [31:0] D_EX_MEM = 32'h2222_b0b0;
    localparam logic [31:0] D_MEM_WB = 32'h3333_c0c0;

    typedef struct packed {
        logic [31:0] instr;
        logic [31:0] pc;
        logic        jump;
        logic [14:0] rd3;
        logic [2:0]  wr3;
        logic        stall;
        logic        we;
        logic [4:0]  wdir;
        logic [31:0] wdata;
        logic [2:0]  sel_a;
        logic [2:0]  sel_b;
    } row_t;

    logic                  clk;
    logic                  i_rst_n;
    logic                  i_stall;
    logic [`ID_DATA_W-1:0] i_instruction;
    logic [`ID_DATA_W-1:0] i_pc;
    logic                  i_jump_brch;
    logic [`ID_REG_AW-1:0] i_w_dir;
    logic [`ID_DATA_W-1:0] i_w_data;
    logic                  i_write_enable;
    logic [`ID_REG_AW-1:0] i_rd_id_ex, i_rd_ex_mem, i_rd_mem_wb;
    logic                  i_reg_wr_id_ex, i_reg_wr_ex_mem, i_reg_wr_mem_wb;
    logic [`ID_DATA_W-1:0] i_data_id_ex, i_data_ex_mem, i_data_mem_wb;
    logic                  o_valid;
    logic [`ID_OP_W-1:0]   o_op;
    logic [`ID_DATA_W-1:0] o_reg_a, o_reg_b, o_reg_a_branch, o_reg_b_branch, o_immediate;
    logic [25:0]           o_jmp_direc;
    logic [`ID_REG_AW-1:0] o_dir_rs, o_dir_rt, o_dir_rd;

    row_t        tbl [NUM_ROWS];
    row_t        cur;
    logic [31:0] mirror [`ID_NUM_REGS];
    int          err_count = 0;
    int          fail_tests = 0;
    int          row_errs;

    // expected latch contents, held across stalled rows
    logic        exp_valid = 1'b0;
    logic [5:0]  exp_op = '0;
    logic [31:0] exp_a = '0, exp_b = '0, exp_a_br = '0, exp_b_br = '0, exp_imm = '0;
    logic [25:0] exp_jmp = '0;
    logic [4:0]  exp_rs = '0, exp_rt = '0, exp_rd = '0;

    id_stage i_id_stage (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        #((NUM_ROWS + NUM_PRE + 10) * 4);
        $display("watchdog expired before the tests finished");
        $display("Result: FAILED");
        $finish;
    end

    // ********************************************************************
    // reference model
    // ********************************************************************
    function automatic logic [31:0] bank_read(input logic [4:0] addr);
        if (addr == '0)
            return '0;
        if (cur.we && cur.wdir == addr)
            return cur.wdata;
        return mirror[addr];
    endfunction

    function automatic logic [31:0] pick_operand(input logic [2:0] sel, input logic [4:0] addr);
        case (sel)
            S_ID_EX:  return D_ID_EX;
            S_EX_MEM: return D_EX_MEM;
            S_MEM_WB: return D_MEM_WB;
            S_PC:     return cur.pc;
            default:  return bank_read(addr);
        endcase
    endfunction

    task automatic predict();
        if (!cur.stall) begin
            exp_valid = 1'b1;
            exp_op    = cur.instr[31:26];
            exp_rs    = cur.instr[25:21];
            exp_rt    = cur.instr[20:16];
            exp_rd    = cur.instr[15:11];
            exp_jmp   = cur.instr[25:0];
            exp_imm   = {{16{cur.instr[15]}}, cur.instr[15:0]};
            exp_a     = pick_operand(cur.sel_a, exp_rs);
            exp_b     = pick_operand(cur.sel_b, exp_rt);
            exp_a_br  = bank_read(exp_rs);
            exp_b_br  = bank_read(exp_rt);
        end
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            $display("error at %0t ns: %s is %h, expected %h", $time, what, got, want);
            err_count++;
            row_errs++;
        end
    endtask

    task automatic check_outputs();
        check_value("o_valid", 32'(o_valid), 32'(exp_valid));
        check_value("o_op", 32'(o_op), 32'(exp_op));
        check_value("o_reg_a", o_reg_a, exp_a);
        check_value("o_reg_b", o_reg_b, exp_b);
        check_value("o_reg_a_branch", o_reg_a_branch, exp_a_br);
        check_value("o_reg_b_branch", o_reg_b_branch, exp_b_br);
        check_value("o_immediate", o_immediate, exp_imm);
        check_value("o_jmp_direc", 32'(o_jmp_direc), 32'(exp_jmp));
        check_value("o_dir_rs", 32'(o_dir_rs), 32'(exp_rs));
        check_value("o_dir_rt", 32'(o_dir_rt), 32'(exp_rt));
        check_value("o_dir_rd", 32'(o_dir_rd), 32'(exp_rd));
    endtask

    task automatic report(input string name);
        $display("test %s: %s", name, (row_errs == 0) ? "ok" : "mismatch");
        if (row_errs != 0)
            fail_tests++;
        row_errs = 0;
    endtask

    // ********************************************************************
    // stimulus
    // ********************************************************************
    initial begin
        // instr, pc, jump, {rd id/ex, ex/mem, mem/wb}, wr flags, stall, we, wdir, wdata, sel
        tbl[0]  = '{{6'h08, 5'd1, 5'd2, 16'h1234}, 32'h0, 1'b0, {5'd0, 5'd0, 5'd0}, 3'b000,
                    1'b0, 1'b0, 5'd0, 32'h0, S_BANK, S_BANK};
        tbl[1]  = '{{6'h23, 5'd3, 5'd0, 16'h8001}, 32'h0, 1'b0, {5'd0, 5'd0, 5'd0}, 3'b000,
                    1'b0, 1'b0, 5'd0, 32'h0, S_BANK, S_BANK};
        tbl[2]  = '{{6'h00, 5'd4, 5'd5, 16'h3020}, 32'h0, 1'b0, {5'd0, 5'd0, 5'd0}, 3'b000,
                    1'b0, 1'b1, 5'd4, 32'hcafe_0004, S_BANK, S_BANK};
        tbl[3]  = '{{6'h00, 5'd1, 5'd2, 16'h1820}, 32'h0, 1'b0, {5'd1, 5'd1, 5'd1}, 3'b111,
                    1'b0, 1'b0, 5'd0, 32'h0, S_ID_EX, S_BANK};
        tbl[4]  = '{{6'h00, 5'd1, 5'd2, 16'h1820}, 32'h0, 1'b0, {5'd1, 5'd1, 5'd1}, 3'b011,
                    1'b0, 1'b0, 5'd0, 32'h0, S_EX_MEM, S_BANK};
        tbl[5]  = '{{6'h00, 5'd1, 5'd2, 16'h1820}, 32'h0, 1'b0, {5'd1, 5'd1, 5'd1}, 3'b001,
                    1'b0, 1'b0, 5'd0, 32'h0, S_MEM_WB, S_BANK};
        // rt also picks up a same-cycle write through the bypass
        tbl[6]  = '{{6'h00, 5'd6, 5'd7, 16'h4020}, 32'h0, 1'b0, {5'd6, 5'd6, 5'd6}, 3'b000,
                    1'b0, 1'b1, 5'd7, 32'h7777_0007, S_BANK, S_BANK};
        tbl[7]  = '{{6'h00, 5'd0, 5'd0, 16'h0020}, 32'h0, 1'b0, {5'd0, 5'd0, 5'd0}, 3'b111,
                    1'b0, 1'b0, 5'd0, 32'h0, S_BANK, S_BANK};
        tbl[8]  = '{{6'h04, 5'd2, 5'd7, 16'hfffc}, 32'h0, 1'b0, {5'd3, 5'd7, 5'd7}, 3'b111,
                    1'b0, 1'b0, 5'd0, 32'h0, S_BANK, S_EX_MEM};
        tbl[9]  = '{{6'h02, 5'd1, 5'd2, 16'h3456}, 32'h0040_0100, 1'b1, {5'd1, 5'd0, 5'd0},
                    3'b100, 1'b0, 1'b0, 5'd0, 32'h0, S_PC, S_BANK};
        tbl[10] = '{{6'h2b, 5'd3, 5'd4, 16'h0010}, 32'h0040_0200, 1'b0, {5'd0, 5'd0, 5'd0},
                    3'b000, 1'b1, 1'b0, 5'd0, 32'h0, S_BANK, S_BANK};
        tbl[11] = '{{6'h00, 5'd8, 5'd5, 16'h2820}, 32'h0, 1'b0, {5'd8, 5'd0, 5'd5}, 3'b101,
                    1'b0, 1'b0, 5'd0, 32'h0, S_ID_EX, S_MEM_WB};
        tbl[12] = '{{6'h00, 5'd0, 5'd3, 16'h0820}, 32'h0, 1'b0, {5'd0, 5'd0, 5'd0}, 3'b000,
                    1'b0, 1'b1, 5'd0, 32'hffff_ffff, S_BANK, S_BANK};
    end

    initial begin
        void'($urandom(32'h9cd0));
        i_rst_n = 1'b0;
        i_stall = 1'b1;
        i_instruction = '0;
        i_pc = '0;
        i_jump_brch = 1'b0;
        i_w_dir = '0;
        i_w_data = '0;
        i_write_enable = 1'b0;
        {i_rd_id_ex, i_rd_ex_mem, i_rd_mem_wb} = '0;
        {i_reg_wr_id_ex, i_reg_wr_ex_mem, i_reg_wr_mem_wb} = '0;
        i_data_id_ex = D_ID_EX;
        i_data_ex_mem = D_EX_MEM;
        i_data_mem_wb = D_MEM_WB;
        foreach (mirror[r])
            mirror[r] = '0;
        row_errs = 0;

        repeat (2) @(posedge clk);
        @(negedge clk);
        i_rst_n = 1'b1;
        check_outputs();
        report("reset");

        // preload through write-back with the latch stalled, reg 0 included
        for (int r = 0; r < NUM_PRE; r++) begin
            i_write_enable = 1'b1;
            i_w_dir = r[4:0];
            i_w_data = $urandom;
            @(posedge clk);
            if (r != 0)
                mirror[r] = i_w_data;
            @(negedge clk);
        end
        i_write_enable = 1'b0;
        check_outputs();
        report("stalled preload");

        for (int n = 0; n < NUM_ROWS; n++) begin
            cur = tbl[n];
            i_instruction = cur.instr;
            i_pc = cur.pc;
            i_jump_brch = cur.jump;
            {i_rd_id_ex, i_rd_ex_mem, i_rd_mem_wb} = cur.rd3;
            {i_reg_wr_id_ex, i_reg_wr_ex_mem, i_reg_wr_mem_wb} = cur.wr3;
            i_stall = cur.stall;
            i_write_enable = cur.we;
            i_w_dir = cur.wdir;
            i_w_data = cur.wdata;
            predict();
            @(posedge clk);
            if (cur.we && cur.wdir != '0)
                mirror[cur.wdir] = cur.wdata;
            @(negedge clk);
            check_outputs();
            report($sformatf("row %0d", n));
        end

        $display("tests %0d, failed %0d, mismatches %0d", NUM_ROWS + 2, fail_tests, err_count);
        if (err_count == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+verilog
verilog/id_pkg.sv
verilog/fwd_src_if.sv
verilog/field_decoder.sv
verilog/register_bank.sv
verilog/operand_forward.sv
verilog/id_ex_latch.sv
verilog/id_stage.sv
tb/id_stage_sva.sv
tb/id_stage_tb.sv

// ==== Makefile ====
# Verilator flow for the ID stage testbench

LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f filelist.f --top-module id_stage_tb -o id_stage_tb

run: compile
	./obj_dir/id_stage_tb | tee $(LOG)
	grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
